/* Makefile */
# Verilator build and run for the UART echo testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_uart_echo -Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

/* compile.f */
logic/uart_pkg.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/uart_echo_queue.sv
logic/uart_echo_top.sv
testbench/tb_uart_echo.sv

/* logic/uart_echo_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_echo_queue import uart_pkg::*; (
    input  wire        clk,
    input  wire        reset,

    input  wire  [7:0] rx_data,
    input  wire        rx_valid,

    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  wire        tx_ready
);
    logic [7:0]                mem [ECHO_DEPTH];
    logic [ECHO_PTR_WIDTH-1:0] wr_ptr;
    logic [ECHO_PTR_WIDTH-1:0] rd_ptr;
    logic [ECHO_PTR_WIDTH:0]   count;
    logic                      full;
    logic                      push;
    logic                      pop;

    assign full = (count == (ECHO_PTR_WIDTH + 1)'(ECHO_DEPTH));
    assign push = rx_valid && !full;  // a byte that finds the queue full is dropped
    assign pop  = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // oldest entry sits at the read pointer and stays put until popped
    assign tx_data  = mem[rd_ptr];
    assign tx_valid = (count != '0);

    // the transmitter drains a byte per frame, so the receiver never outruns it
    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset) rx_valid |-> !full);

    // equal pointers with the queue not full means there is nothing to pop
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> (rd_ptr != wr_ptr) || full);

endmodule

`default_nettype wire

/* logic/uart_echo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_echo_top (
    input  wire        clk,
    input  wire        reset,

    input  wire        serial_in,
    output logic       serial_out,

    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_frame_error
);
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    // receiver strobes go both to the pins and into the echo path
    uart_receiver u_receiver (
        .clk            (clk),
        .reset          (reset),
        .serial_in      (serial_in),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_frame_error (rx_frame_error)
    );

    uart_echo_queue u_echo_queue (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    uart_transmitter u_transmitter (
        .clk           (clk),
        .reset         (reset),
        .data_in       (tx_data),
        .data_in_valid (tx_valid),
        .data_in_ready (tx_ready),
        .serial_out    (serial_out)
    );

endmodule

`default_nettype wire

/* logic/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // system clock and line rate
    localparam int CLOCK_FREQ = 125_000_000;
    localparam int BAUD_RATE  = 115_200;

    // cycles per bit on the serial line
    localparam int SYMBOL_EDGE_TIME = CLOCK_FREQ / BAUD_RATE;
    localparam int HALF_SYMBOL_TIME = SYMBOL_EDGE_TIME / 2;

    // one spare bit so a full symbol count never wraps
    localparam int CLOCK_COUNTER_WIDTH = $clog2(SYMBOL_EDGE_TIME) + 1;

    // echo queue sizing, depth must stay a power of two
    localparam int ECHO_DEPTH     = 4;
    localparam int ECHO_PTR_WIDTH = $clog2(ECHO_DEPTH);

endpackage

`default_nettype wire

/* logic/uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_receiver import uart_pkg::*; (
    input  wire        clk,
    input  wire        reset,

    input  wire        serial_in,

    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_frame_error
);
    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] START = 2'd1;
    localparam logic [1:0] DATA  = 2'd2;
    localparam logic [1:0] STOP  = 2'd3;

    logic                           sync_0;
    logic                           sync_1;
    logic                           line_prev;
    logic                           start_edge;
    logic [1:0]                     state;
    logic [2:0]                     bit_counter;
    logic [CLOCK_COUNTER_WIDTH-1:0] clock_counter;
    logic                           half_done;
    logic                           bit_done;
    logic [7:0]                     rx_shift;

    // two flops against metastability, then one more to see the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_0    <= 1'b1;
            sync_1    <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_0    <= serial_in;
            sync_1    <= sync_0;
            line_prev <= sync_1;
        end
    end

    assign start_edge = line_prev && !sync_1;
    assign half_done  = (clock_counter == CLOCK_COUNTER_WIDTH'(HALF_SYMBOL_TIME - 1));
    assign bit_done   = (clock_counter == CLOCK_COUNTER_WIDTH'(SYMBOL_EDGE_TIME - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= IDLE;
            bit_counter    <= '0;
            clock_counter  <= '0;
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            rx_valid       <= 1'b0;
            rx_frame_error <= 1'b0;
            case (state)
                IDLE: begin
                    clock_counter <= '0;
                    bit_counter   <= '0;
                    if (start_edge) begin
                        state <= START;
                    end
                end
                START: begin
                    if (half_done) begin
                        clock_counter <= '0;
                        // a short low glitch is not a start bit
                        state <= sync_1 ? IDLE : DATA;
                    end else begin
                        clock_counter <= clock_counter + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        clock_counter <= '0;
                        bit_counter   <= bit_counter + 3'd1;
                        if (bit_counter == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        clock_counter <= clock_counter + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        clock_counter  <= '0;
                        rx_valid       <= sync_1;
                        rx_frame_error <= !sync_1;  // stop bit sampled low
                        state          <= IDLE;
                    end else begin
                        clock_counter <= clock_counter + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // data bits arrive lsb first and settle toward bit 0
    always_ff @(posedge clk) begin
        if (state == DATA && bit_done) begin
            rx_shift <= {sync_1, rx_shift[7:1]};
        end
    end

    assign rx_data = rx_shift;

    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset) !(rx_valid && rx_frame_error));

endmodule

`default_nettype wire

/* logic/uart_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter import uart_pkg::*; (
    input  wire        clk,
    input  wire        reset,

    input  wire  [7:0] data_in,
    input  wire        data_in_valid,
    output logic       data_in_ready,

    output logic       serial_out
);
    localparam logic [2:0] IDLE    = 3'b001;
    localparam logic [2:0] LATCH   = 3'b010;
    localparam logic [2:0] SENDING = 3'b100;

    logic [2:0]                     state;
    logic [2:0]                     next_state;
    logic [7:0]                     data_hold;
    logic [9:0]                     tx_shift;
    logic [3:0]                     bit_counter;
    logic [CLOCK_COUNTER_WIDTH-1:0] clock_counter;
    logic                           bit_done;

    assign bit_done = (clock_counter == CLOCK_COUNTER_WIDTH'(SYMBOL_EDGE_TIME - 1));

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (data_in_valid) begin
                    next_state = LATCH;
                end
            end
            LATCH: begin
                next_state = SENDING;
            end
            SENDING: begin
                if (bit_done && bit_counter == 4'd9) begin  // stop bit has run its full period
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // byte is captured at the handshake, the queue may move on right after
    always_ff @(posedge clk) begin
        if (data_in_valid && data_in_ready) begin
            data_hold <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            tx_shift      <= '1;
            bit_counter   <= '0;
            clock_counter <= '0;
        end else begin
            state <= next_state;
            case (state)
                LATCH: begin
                    tx_shift      <= {1'b1, data_hold, 1'b0};  // stop, data, start
                    bit_counter   <= '0;
                    clock_counter <= '0;
                end
                SENDING: begin
                    if (bit_done) begin
                        tx_shift      <= {1'b1, tx_shift[9:1]};  // lsb goes out first
                        bit_counter   <= bit_counter + 4'd1;
                        clock_counter <= '0;
                    end else begin
                        clock_counter <= clock_counter + 1'b1;
                    end
                end
                default: begin
                    tx_shift      <= '1;
                    bit_counter   <= '0;
                    clock_counter <= '0;
                end
            endcase
        end
    end

    assign data_in_ready = (state == IDLE);
    assign serial_out    = tx_shift[0];

    a_state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state));

    // line must rest at the mark level between frames
    a_idle_line_high: assert property (
        @(posedge clk) disable iff (reset) (state == IDLE) |-> serial_out);

endmodule

`default_nettype wire

/* testbench/tb_uart_echo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_echo import uart_pkg::*; ();
    localparam int FRAME_CYCLES = 10 * SYMBOL_EDGE_TIME;
    localparam int WAIT_LIMIT   = 4 * FRAME_CYCLES;  // bound for every wait loop

    logic       clk;
    logic       reset;
    logic       serial_in;
    logic       serial_out;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_frame_error;

    logic [7:0]  frame_data[$];   // frames of the running test
    logic        frame_bad[$];
    logic [8:0]  exp_events[$];   // bit 8 marks a framing error
    logic [7:0]  exp_echoes[$];
    logic [7:0]  echoes_seen[$];
    logic [31:0] lfsr_state;
    string       test_name;
    int          value_errors;
    int          fault_count;

    uart_echo_top DUT (
        .clk            (clk),
        .reset          (reset),
        .serial_in      (serial_in),
        .serial_out     (serial_out),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_frame_error (rx_frame_error)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++) begin
            value[i] = take_bit();
        end
        return value;
    endfunction

    // every frame yields one strobe, only good frames come back on the line
    function automatic void predict_results();
        for (int i = 0; i < frame_data.size(); i++) begin
            exp_events.push_back({frame_bad[i], frame_data[i]});
            if (!frame_bad[i]) begin
                exp_echoes.push_back(frame_data[i]);
            end
        end
    endfunction

    task automatic check_byte(input string what, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error [%s] %s: expected 8'h%02h, actual 8'h%02h",
                     test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error [%s] %s: expected %b, actual %b", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        logic [9:0] bits;
        bits = {~bad_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            serial_in = bits[i];
            repeat (SYMBOL_EDGE_TIME) @(posedge clk);
            #1;
        end
        // a low stop bit would merge with the next start bit, so rest at mark for a bit
        if (bad_stop) begin
            serial_in = 1'b1;
            repeat (SYMBOL_EDGE_TIME) @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_events_drained();
        int cycles;
        cycles = 0;
        while (exp_events.size() != 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (exp_events.size() != 0) begin
            $display("[%s] timed out with %0d receiver strobes still missing",
                     test_name, exp_events.size());
            fault_count++;
        end
    endtask

    task automatic wait_echoes(input int total);
        int cycles;
        cycles = 0;
        while (echoes_seen.size() < total && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (echoes_seen.size() < total) begin
            $display("[%s] timed out waiting for echoes, got %0d of %0d",
                     test_name, echoes_seen.size(), total);
            fault_count++;
        end
    endtask

    task automatic run_frames();
        int first_echo;
        first_echo = exp_echoes.size();
        predict_results();
        for (int i = 0; i < frame_data.size(); i++) begin
            send_frame(frame_data[i], frame_bad[i]);
        end
        wait_events_drained();
        wait_echoes(exp_echoes.size());
        for (int i = first_echo; i < exp_echoes.size() && i < echoes_seen.size(); i++) begin
            check_byte("echoed byte", exp_echoes[i], echoes_seen[i]);
        end
        frame_data.delete();
        frame_bad.delete();
    endtask

    // strobes are compared on the falling edge, away from the DUT's updates
    always @(negedge clk) begin : compare_events
        logic [8:0] expected;
        if (!reset && (rx_valid || rx_frame_error)) begin
            if (exp_events.size() == 0) begin
                $display("[%s] receiver strobe at %0t with no frame outstanding",
                         test_name, $time);
                fault_count++;
            end else begin
                expected = exp_events.pop_front();
                check_flag("rx_frame_error", expected[8], rx_frame_error);
                check_flag("rx_valid", !expected[8], rx_valid);
                if (!expected[8]) begin
                    check_byte("rx_data", expected[7:0], rx_data);
                end
            end
        end
    end

    initial begin : decode_serial_out
        logic [7:0] decoded;
        forever begin
            @(negedge clk);
            if (!reset && serial_out === 1'b0) begin
                repeat (HALF_SYMBOL_TIME) @(negedge clk);  // centre of the start bit
                check_flag("echo start bit", 1'b0, serial_out);
                for (int i = 0; i < 8; i++) begin
                    repeat (SYMBOL_EDGE_TIME) @(negedge clk);
                    decoded[i] = serial_out;
                end
                repeat (SYMBOL_EDGE_TIME) @(negedge clk);
                check_flag("echo stop bit", 1'b1, serial_out);
                echoes_seen.push_back(decoded);
            end
        end
    end

    initial begin : main_flow
        logic bad;
        int   good_count;
        int   first_seen;
        clk          = 1'b0;
        reset        = 1'b1;
        serial_in    = 1'b1;
        lfsr_state   = 32'h887b;
        value_errors = 0;
        fault_count  = 0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_flag("serial_out idle", 1'b1, serial_out);
        check_flag("rx_valid idle", 1'b0, rx_valid);
        check_flag("rx_frame_error idle", 1'b0, rx_frame_error);
        repeat (2 * FRAME_CYCLES) @(posedge clk);  // any strobe here is unexpected
        #1;

        test_name = "single byte";
        frame_data.push_back(8'h5a);
        frame_bad.push_back(1'b0);
        run_frames();

        test_name = "back to back";
        for (int i = 0; i < 8; i++) begin
            frame_data.push_back(random_byte());
            frame_bad.push_back(1'b0);
        end
        run_frames();

        test_name = "bad stop bit";
        frame_data.push_back(8'hc3);
        frame_bad.push_back(1'b1);
        run_frames();
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        #1;
        check_byte("echo count after bad frame", 8'(exp_echoes.size()), 8'(echoes_seen.size()));
        test_name = "good after bad";
        frame_data.push_back(8'h3c);
        frame_bad.push_back(1'b0);
        run_frames();

        test_name  = "mixed frames";
        first_seen = echoes_seen.size();
        good_count = 0;
        for (int i = 0; i < 12; i++) begin
            frame_data.push_back(random_byte());
            bad = take_bit();
            bad = bad & take_bit();  // roughly one frame in four is broken
            frame_bad.push_back(bad);
            if (!bad) begin
                good_count++;
            end
        end
        run_frames();
        check_byte("echo count", 8'(good_count), 8'(echoes_seen.size() - first_seen));

        $display("errors: %0d value mismatches, %0d protocol faults", value_errors, fault_count);
        if (value_errors == 0 && fault_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
